//--- verilog/theta_pkg.sv
`default_nettype none

package theta_pkg;

    // ========================================
    // Fixed-point format and sizes
    // ========================================

    // Q4.14 signed samples throughout
    localparam int SAMPLE_WIDTH = 18;
    localparam int FRAC_BITS = 14;

    // One CA3 unit per cortical oscillator
    localparam int N_UNITS = 6;

    // Sample enable divider, the fast-sim ratio
    localparam int CLK_DIV = 10;
    localparam int CLK_DIV_WIDTH = $clog2(CLK_DIV);

    // Theta accumulator and its table address
    localparam int PHASE_ACC_WIDTH = 16;
    localparam int PHASE_WIDTH = 3;
    localparam int TABLE_ADDR_WIDTH = 5;

    // ========================================
    // Types
    // ========================================

    typedef logic signed [SAMPLE_WIDTH-1:0] theta_sample_t;
    typedef logic [PHASE_WIDTH-1:0] theta_phase_t;
    typedef logic [N_UNITS-1:0] unit_pattern_t;
    typedef logic signed [3:0] hebb_count_t;

    // Field order follows pattern bits 0 to 5
    typedef struct packed {
        theta_sample_t sensory_l23;
        theta_sample_t sensory_l6;
        theta_sample_t assoc_l23;
        theta_sample_t assoc_l6;
        theta_sample_t motor_l23;
        theta_sample_t motor_l6;
    } cortical_layers_t;

    typedef struct packed {
        theta_sample_t sensory_l23;
        theta_sample_t sensory_l6;
        theta_sample_t assoc_l23;
        theta_sample_t assoc_l6;
        theta_sample_t motor_l23;
        theta_sample_t motor_l6;
    } phase_couple_t;

    // ========================================
    // Constants
    // ========================================

    // Coupling gain, 0.25
    localparam theta_sample_t K_PHASE = 18'sd4096;

    // 64 samples per theta cycle
    localparam logic [PHASE_ACC_WIDTH-1:0] THETA_STEP = 16'd1024;

    // Phases 0-3 encode, 4-7 retrieve
    localparam theta_phase_t ENCODE_PHASES = 3'd4;

    // Hebbian counter limit, symmetric
    localparam hebb_count_t HEBB_MAX = 4'sd7;

    // One sine cycle, amplitude 0.75
    localparam theta_sample_t THETA_TABLE [2**TABLE_ADDR_WIDTH] = '{
        18'sd0,      18'sd2397,   18'sd4702,   18'sd6827,
        18'sd8689,   18'sd10217,  18'sd11353,  18'sd12052,
        18'sd12288,  18'sd12052,  18'sd11353,  18'sd10217,
        18'sd8689,   18'sd6827,   18'sd4702,   18'sd2397,
        18'sd0,      -18'sd2397,  -18'sd4702,  -18'sd6827,
        -18'sd8689,  -18'sd10217, -18'sd11353, -18'sd12052,
        -18'sd12288, -18'sd12052, -18'sd11353, -18'sd10217,
        -18'sd8689,  -18'sd6827,  -18'sd4702,  -18'sd2397
    };

endpackage

`default_nettype wire

//--- verilog/sample_clock_enable.sv
`default_nettype none

module sample_clock_enable (
    input  logic clk,
    input  logic rst_n,
    output logic sample_en
);

    import theta_pkg::*;

    // Free-running divider count
    logic [CLK_DIV_WIDTH-1:0] div_cnt;
    logic                     div_wrap;

    // Last count of each sample period
    assign div_wrap = (div_cnt == CLK_DIV_WIDTH'(CLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (div_wrap) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // One clk wide, once per CLK_DIV cycles
    assign sample_en = div_wrap;

endmodule

`default_nettype wire

//--- verilog/theta_oscillator.sv
`default_nettype none

module theta_oscillator (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample_en,
    output theta_pkg::theta_sample_t theta_x,
    output theta_pkg::theta_phase_t  theta_phase
);

    import theta_pkg::*;

    // ========================================
    // Phase accumulator
    // ========================================

    logic [PHASE_ACC_WIDTH-1:0]  phase_acc;
    logic [PHASE_ACC_WIDTH-1:0]  acc_next;
    logic [TABLE_ADDR_WIDTH-1:0] table_addr;

    // Wraps naturally at 2^16
    assign acc_next = phase_acc + THETA_STEP;

    // Top bits select the sine entry
    assign table_addr = acc_next[PHASE_ACC_WIDTH-1 -: TABLE_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_acc <= '0;
        end else if (sample_en) begin
            phase_acc <= acc_next;
        end
    end

    // ========================================
    // Registered sine and eight-phase output
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            theta_x     <= '0;
            theta_phase <= '0;
        end else if (sample_en) begin
            // Same edge as the accumulator update
            theta_x     <= THETA_TABLE[table_addr];
            theta_phase <= acc_next[PHASE_ACC_WIDTH-1 -: PHASE_WIDTH];
        end
    end

endmodule

`default_nettype wire

//--- verilog/ca3_phase_memory.sv
`default_nettype none

module ca3_phase_memory (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sample_en,
    input  theta_pkg::theta_phase_t     theta_phase,
    input  theta_pkg::cortical_layers_t layers,
    output theta_pkg::unit_pattern_t    cortical_pattern,
    output theta_pkg::unit_pattern_t    phase_pattern,
    output logic                      learning,
    output logic                      recalling
);

    import theta_pkg::*;

    // Idle only until the first tick
    typedef enum logic [1:0] {
        IDLE,
        ENCODE,
        RETRIEVE
    } window_t;

    window_t       win_state;
    window_t       win_next;
    unit_pattern_t in_pattern;
    hebb_count_t   hebb [N_UNITS];

    // ========================================
    // Cortical thresholding
    // ========================================

    // Non-negative sample counts as active
    assign in_pattern[0] = ~layers.sensory_l23[SAMPLE_WIDTH-1];
    assign in_pattern[1] = ~layers.sensory_l6[SAMPLE_WIDTH-1];
    assign in_pattern[2] = ~layers.assoc_l23[SAMPLE_WIDTH-1];
    assign in_pattern[3] = ~layers.assoc_l6[SAMPLE_WIDTH-1];
    assign in_pattern[4] = ~layers.motor_l23[SAMPLE_WIDTH-1];
    assign in_pattern[5] = ~layers.motor_l6[SAMPLE_WIDTH-1];

    // Window from the phase held before this tick
    assign win_next = (theta_phase < ENCODE_PHASES) ? ENCODE : RETRIEVE;

    // ========================================
    // Window state and thresholded pattern
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_state        <= IDLE;
            cortical_pattern <= '0;
        end else if (sample_en) begin
            win_state        <= win_next;
            cortical_pattern <= in_pattern;
        end
    end

    assign learning  = (win_state == ENCODE);
    assign recalling = (win_state == RETRIEVE);

    // ========================================
    // Hebbian counters and recall
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N_UNITS; i++) begin
                hebb[i] <= '0;
            end
            phase_pattern <= '0;
        end else if (sample_en) begin
            if (win_next == ENCODE) begin
                // Step toward the limit set by the input bit
                for (int i = 0; i < N_UNITS; i++) begin
                    if (in_pattern[i] && hebb[i] != HEBB_MAX) begin
                        hebb[i] <= hebb[i] + 4'sd1;
                    end else if (!in_pattern[i] && hebb[i] != -HEBB_MAX) begin
                        hebb[i] <= hebb[i] - 4'sd1;
                    end
                end
            end else begin
                // Counters hold, pattern follows their signs
                for (int i = 0; i < N_UNITS; i++) begin
                    phase_pattern[i] <= (hebb[i] > 0);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/phase_coupling.sv
`default_nettype none

module phase_coupling (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample_en,
    input  theta_pkg::theta_sample_t theta_x,
    input  theta_pkg::unit_pattern_t phase_pattern,
    output theta_pkg::phase_couple_t couple
);

    import theta_pkg::*;

    // Full-width product, Q8.28
    logic signed [2*SAMPLE_WIDTH-1:0] theta_scaled;
    theta_sample_t                    base;
    theta_sample_t                    base_neg;

    assign theta_scaled = K_PHASE * theta_x;

    // Back to Q4.14, sign kept
    assign base     = theta_sample_t'(theta_scaled >>> FRAC_BITS);
    assign base_neg = -base;

    // ========================================
    // Registered per-unit coupling
    // ========================================

    // Bit 1 in phase, bit 0 anti-phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            couple <= '0;
        end else if (sample_en) begin
            couple.sensory_l23 <= phase_pattern[0] ? base : base_neg;
            couple.sensory_l6  <= phase_pattern[1] ? base : base_neg;
            couple.assoc_l23   <= phase_pattern[2] ? base : base_neg;
            couple.assoc_l6    <= phase_pattern[3] ? base : base_neg;
            couple.motor_l23   <= phase_pattern[4] ? base : base_neg;
            couple.motor_l6    <= phase_pattern[5] ? base : base_neg;
        end
    end

endmodule

`default_nettype wire

//--- verilog/theta_phase_memory_top.sv
`default_nettype none

module theta_phase_memory_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  theta_pkg::cortical_layers_t layers,
    output theta_pkg::theta_sample_t    theta_x,
    output theta_pkg::theta_phase_t     theta_phase,
    output theta_pkg::unit_pattern_t    cortical_pattern,
    output theta_pkg::unit_pattern_t    ca3_phase_pattern,
    output logic                      ca3_learning,
    output logic                      ca3_recalling,
    output logic                      sample_valid,
    output theta_pkg::phase_couple_t    phase_couple
);

    logic sample_en;

    // ========================================
    // Sample rate enable
    // ========================================

    sample_clock_enable i_clk_en (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en)
    );

    // Marks the cycle after each update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= sample_en;
        end
    end

    // ========================================
    // Theta, CA3 and coupling loop
    // ========================================

    theta_oscillator i_theta (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_en   (sample_en),
        .theta_x     (theta_x),
        .theta_phase (theta_phase)
    );

    // Theta phase gates learning and recall
    ca3_phase_memory i_ca3 (
        .clk              (clk),
        .rst_n            (rst_n),
        .sample_en        (sample_en),
        .theta_phase      (theta_phase),
        .layers           (layers),
        .cortical_pattern (cortical_pattern),
        .phase_pattern    (ca3_phase_pattern),
        .learning         (ca3_learning),
        .recalling        (ca3_recalling)
    );

    // Recalled bits set the coupling signs
    phase_coupling i_couple (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_en     (sample_en),
        .theta_x       (theta_x),
        .phase_pattern (ca3_phase_pattern),
        .couple        (phase_couple)
    );

endmodule

`default_nettype wire

//--- test/theta_phase_memory_properties.sv
`default_nettype none

module theta_phase_memory_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    sample_en,
    input logic                    sample_valid,
    input logic                    ca3_learning,
    input logic                    ca3_recalling,
    input theta_pkg::theta_phase_t theta_phase
);

    import theta_pkg::*;

    // ========================================
    // Sample timing
    // ========================================

    // One cycle wide
    valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid held for more than one cycle");

    // Repeats every CLK_DIV cycles
    valid_period: assert property (@(posedge clk) disable iff (!rst_n)
        $past(sample_valid, CLK_DIV) |-> sample_valid)
        else $error("sample_valid period differs from CLK_DIV");

    // ========================================
    // Window and phase
    // ========================================

    // Exactly one window after every update, never both
    window_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> (ca3_learning ^ ca3_recalling))
        else $error("ca3_learning and ca3_recalling not exactly one after a tick");

    // Phase moves only on a sample update
    phase_on_enable: assert property (@(posedge clk) disable iff (!rst_n)
        (theta_phase != $past(theta_phase)) |-> $past(sample_en))
        else $error("theta_phase changed without a sample enable");

endmodule

bind theta_phase_memory_top theta_phase_memory_properties i_properties (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_en     (sample_en),
    .sample_valid  (sample_valid),
    .ca3_learning  (ca3_learning),
    .ca3_recalling (ca3_recalling),
    .theta_phase   (theta_phase)
);

`default_nettype wire

//--- test/tb_theta_phase_memory.sv
`default_nettype none

module tb_theta_phase_memory;

    import theta_pkg::*;

    // ========================================
    // Run constants and signals
    // ========================================

    localparam int N_TICKS = 400;
    localparam int TICK_TIMEOUT = CLK_DIV + 2;
    // Two theta cycles with one fixed pattern
    localparam int FIXED_FIRST = 129;
    localparam int FIXED_LAST = 256;
    localparam unit_pattern_t FIXED_MASK = 6'b101101;
    localparam logic [31:0] LFSR_SEED = 32'h82b0_ccbd;

    typedef logic [N_UNITS*SAMPLE_WIDTH-1:0] flat_units_t;

    // Expected DUT state after a tick
    typedef struct packed {
        logic [PHASE_ACC_WIDTH-1:0] acc;
        theta_phase_t               theta_phase;
        theta_sample_t              theta_x;
        unit_pattern_t              cortical;
        unit_pattern_t              pattern;
        logic                       learning;
        logic                       recalling;
        logic [N_UNITS-1:0][3:0]    hebb;
        phase_couple_t              couple;
    } model_t;

    logic             clk = 1'b0;
    logic             rst_n;
    cortical_layers_t layers;
    theta_sample_t    theta_x;
    theta_phase_t     theta_phase;
    unit_pattern_t    cortical_pattern;
    unit_pattern_t    ca3_phase_pattern;
    logic             ca3_learning;
    logic             ca3_recalling;
    logic             sample_valid;
    phase_couple_t    phase_couple;

    logic [31:0]      lfsr_state;
    model_t           model;
    model_t           idle_model;
    cortical_layers_t tick_layers;
    cortical_layers_t applied_q[$];
    int               ticks_checked;
    int               error_count;
    int               tick_cycles;

    theta_phase_memory_top i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .layers            (layers),
        .theta_x           (theta_x),
        .theta_phase       (theta_phase),
        .cortical_pattern  (cortical_pattern),
        .ca3_phase_pattern (ca3_phase_pattern),
        .ca3_learning      (ca3_learning),
        .ca3_recalling     (ca3_recalling),
        .sample_valid      (sample_valid),
        .phase_couple      (phase_couple)
    );

    always #50 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    // Unit i sits at pattern bit i, first struct field is unit 0
    function automatic int field_lsb(input int i);
        return (N_UNITS - 1 - i) * SAMPLE_WIDTH;
    endfunction

    function automatic string unit_name(input int i);
        case (i)
            0: return "sensory_l23";
            1: return "sensory_l6";
            2: return "assoc_l23";
            3: return "assoc_l6";
            4: return "motor_l23";
            default: return "motor_l6";
        endcase
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // Non-negative sample is an active bit
    function automatic unit_pattern_t sign_pattern(input cortical_layers_t l);
        flat_units_t   flat;
        unit_pattern_t bits;
        flat = l;
        for (int i = 0; i < N_UNITS; i++) begin
            bits[i] = ~flat[field_lsb(i) + SAMPLE_WIDTH - 1];
        end
        return bits;
    endfunction

    // ========================================
    // Reference model, one tick
    // ========================================

    function automatic model_t model_tick(input model_t m, input cortical_layers_t l);
        model_t        n;
        unit_pattern_t bits;
        flat_units_t   couple_flat;
        longint        prod;
        theta_sample_t base;
        int            h;
        n = m;
        bits = sign_pattern(l);
        // Coupling uses theta and pattern from the previous tick
        prod = longint'(K_PHASE) * longint'(m.theta_x);
        base = theta_sample_t'(prod >>> FRAC_BITS);
        for (int i = 0; i < N_UNITS; i++) begin
            couple_flat[field_lsb(i) +: SAMPLE_WIDTH] = m.pattern[i] ? base : -base;
        end
        n.couple = phase_couple_t'(couple_flat);
        // Accumulator is k times the step
        n.acc = m.acc + THETA_STEP;
        n.theta_phase = n.acc[PHASE_ACC_WIDTH-1 -: 3];
        n.theta_x = THETA_TABLE[n.acc[PHASE_ACC_WIDTH-1 -: 5]];
        n.cortical = bits;
        // Window from the phase held before this tick
        if (m.theta_phase < ENCODE_PHASES) begin
            n.learning = 1'b1;
            n.recalling = 1'b0;
            for (int i = 0; i < N_UNITS; i++) begin
                h = $signed(m.hebb[i]);
                if (bits[i] && h < HEBB_MAX) begin
                    h = h + 1;
                end else if (!bits[i] && h > -HEBB_MAX) begin
                    h = h - 1;
                end
                n.hebb[i] = 4'(h);
            end
        end else begin
            n.learning = 1'b0;
            n.recalling = 1'b1;
            for (int i = 0; i < N_UNITS; i++) begin
                n.pattern[i] = ($signed(m.hebb[i]) > 0);
            end
        end
        return n;
    endfunction

    // ========================================
    // Checking
    // ========================================

    task automatic stop_on_failure();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic signed [31:0] actual,
                               input logic signed [31:0] expected);
        assert (actual === expected) else begin
            error_count++;
            $display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic compare_outputs(input model_t m);
        flat_units_t got_flat;
        flat_units_t exp_flat;
        got_flat = phase_couple;
        exp_flat = m.couple;
        check_field("theta_phase", theta_phase, m.theta_phase);
        check_field("theta_x", theta_x, m.theta_x);
        check_field("cortical_pattern", cortical_pattern, m.cortical);
        check_field("ca3_phase_pattern", ca3_phase_pattern, m.pattern);
        check_field("ca3_learning", ca3_learning, m.learning);
        check_field("ca3_recalling", ca3_recalling, m.recalling);
        for (int i = 0; i < N_UNITS; i++) begin
            check_field({"phase_couple.", unit_name(i)},
                        $signed(got_flat[field_lsb(i) +: SAMPLE_WIDTH]),
                        $signed(exp_flat[field_lsb(i) +: SAMPLE_WIDTH]));
        end
    endtask

    // Pops the layers of this tick, steps the model and compares
    always @(negedge clk) begin
        if (rst_n === 1'b1 && sample_valid === 1'b1) begin
            if (applied_q.size() == 0) begin
                $display("ERROR: no layers were recorded for tick %0d", ticks_checked + 1);
                stop_on_failure();
            end else begin
                tick_layers = applied_q.pop_front();
                model = model_tick(model, tick_layers);
                ticks_checked++;
                compare_outputs(model);
                // Saturated counters recall the fixed pattern
                if (ticks_checked == FIXED_LAST) begin
                    check_field("ca3_phase_pattern after fixed run", ca3_phase_pattern,
                                FIXED_MASK);
                end
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic drive_tick_layers(input int tick);
        logic [31:0] bits;
        flat_units_t flat;
        flat = '0;
        for (int i = 0; i < N_UNITS; i++) begin
            if (tick >= FIXED_FIRST && tick <= FIXED_LAST) begin
                // Sign forced by the mask, magnitude random
                take_bits(SAMPLE_WIDTH - 1, bits);
                flat[field_lsb(i) +: SAMPLE_WIDTH] = {~FIXED_MASK[i], bits[SAMPLE_WIDTH-2:0]};
            end else begin
                take_bits(SAMPLE_WIDTH, bits);
                flat[field_lsb(i) +: SAMPLE_WIDTH] = bits[SAMPLE_WIDTH-1:0];
            end
        end
        layers = cortical_layers_t'(flat);
        applied_q.push_back(cortical_layers_t'(flat));
    endtask

    // Returns on the falling edge where sample_valid is high
    task automatic wait_sample_valid(input int max_cycles, input logic check_idle,
                                     input string what, output int waited);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
            if (sample_valid === 1'b1) begin
                seen = 1'b1;
            end else if (check_idle) begin
                compare_outputs(idle_model);
            end
        end
        waited = cycles;
        if (!seen) begin
            $display("TIMEOUT: %s did not arrive within %0d cycles", what, max_cycles);
            stop_on_failure();
        end
    endtask

    task automatic wait_checks_done(input int max_cycles);
        int cycles;
        cycles = 0;
        while (ticks_checked < N_TICKS && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (ticks_checked < N_TICKS) begin
            $display("TIMEOUT: only %0d of %0d ticks were compared", ticks_checked, N_TICKS);
            stop_on_failure();
        end
    endtask

    initial begin
        rst_n = 1'b0;
        layers = '0;
        lfsr_state = LFSR_SEED;
        model = '0;
        idle_model = '0;
        ticks_checked = 0;
        error_count = 0;
        tick_cycles = 0;
        drive_tick_layers(1);

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Outputs stay idle until the first pulse, CLK_DIV cycles after reset
        wait_sample_valid(TICK_TIMEOUT, 1'b1, "first sample_valid after reset", tick_cycles);
        check_field("sample_valid interval", tick_cycles, CLK_DIV);
        for (int tick = 1; tick <= N_TICKS; tick++) begin
            if (tick > 1) begin
                wait_sample_valid(TICK_TIMEOUT, 1'b0, "sample_valid for the next tick",
                                  tick_cycles);
                check_field("sample_valid interval", tick_cycles, CLK_DIV);
            end
            // New layers for the following tick
            if (tick < N_TICKS) begin
                drive_tick_layers(tick + 1);
            end
        end
        wait_checks_done(TICK_TIMEOUT);

        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- theta_phase_memory.f
verilog/theta_pkg.sv
verilog/sample_clock_enable.sv
verilog/theta_oscillator.sv
verilog/ca3_phase_memory.sv
verilog/phase_coupling.sv
verilog/theta_phase_memory_top.sv
test/theta_phase_memory_properties.sv
test/tb_theta_phase_memory.sv

//--- run_sim.sh
#!/bin/sh
# Builds the theta phase memory testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

FILE_LIST=theta_phase_memory.f
TB_TOP=tb_theta_phase_memory
BUILD_DIR=obj_dir
SIM_BIN=sim_tb
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

echo "Building ${TB_TOP}"
if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module "${TB_TOP}" -Mdir "${BUILD_DIR}" -o "${SIM_BIN}" \
        -f "${FILE_LIST}" > "${BUILD_LOG}" 2>&1; then
    cat "${BUILD_LOG}"
    echo "Build failed"
    exit 1
fi

echo "Running simulation"
"./${BUILD_DIR}/${SIM_BIN}" > "${SIM_LOG}" 2>&1
sim_status=$?
cat "${SIM_LOG}"

if [ "${sim_status}" -ne 0 ]; then
    echo "Simulation exited with status ${sim_status}"
    exit 1
fi

if grep -q -x "PASS: all tests" "${SIM_LOG}"; then
    echo "Result: passed"
    exit 0
fi

echo "Result: failed"
exit 1
